/* Makefile */
TOP = tb_wb_interconnect

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* all.f */
common/wb_ic_pkg.sv
wb_interconnect/wb_ic_arbiter.sv
wb_interconnect/wb_ic_ctrl.sv
source/wb_ic_target_mux.sv
source/wb_ic_master_mux.sv
source/wb_ic_err_target.sv
wb_interconnect/wb_interconnect_2x2.sv
testbench/tb_wb_interconnect.sv

/* common/wb_ic_pkg.sv */
//############################################################
// Wishbone 2x2 crossbar definitions
//############################################################
`default_nettype none

package wb_ic_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W  = 4;

	// Two masters, two slaves plus the decode-error target
	localparam int N_MASTERS = 2;
	localparam int N_TARGETS = 3;

	// Address map, limits inclusive
	localparam logic [ADDR_W-1:0] S0_BASE  = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] S0_LIMIT = 32'h0000_0FFF;
	localparam logic [ADDR_W-1:0] S1_BASE  = 32'h0001_0000;
	localparam logic [ADDR_W-1:0] S1_LIMIT = 32'h0001_0FFF;

	typedef logic [ADDR_W-1:0] wb_addr_t;
	typedef logic [DATA_W-1:0] wb_data_t;
	typedef logic [SEL_W-1:0]  wb_sel_t;

	// Target index, also used to route responses
	typedef logic [1:0] target_id_t;
	localparam target_id_t TGT_S0   = 2'd0;
	localparam target_id_t TGT_S1   = 2'd1;
	localparam target_id_t TGT_ERR  = 2'd2;
	localparam target_id_t TGT_NONE = 2'd3;

	typedef logic [0:0] master_id_t;

	typedef enum logic {M_IDLE, M_BUSY} master_state_e;
	typedef enum logic {A_IDLE, A_GRANTED} arb_state_e;

endpackage

`default_nettype wire

/* source/wb_ic_err_target.sv */
//############################################################
// Decode-error target
//############################################################
`timescale 1ns/1ps
`default_nettype none

module wb_ic_err_target (
	input  wire logic           clk,
	input  wire logic           rstn,
	input  wire logic           cyc_i,
	input  wire logic           stb_i,
	output wb_ic_pkg::wb_data_t dat_o,
	output logic                ack_o,
	output logic                err_o
);

	logic err_q;
	// Set after a pulse, cleared once STB goes away
	logic done_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q  <= 1'b0;
			done_q <= 1'b0;
		end else begin
			// One ERR per strobe
			err_q <= cyc_i && stb_i && !err_q && !done_q;
			if (!stb_i)
				done_q <= 1'b0;
			else if (err_q)
				done_q <= 1'b1;
		end
	end

	assign err_o = err_q;
	// Never acks, never returns data
	assign ack_o = 1'b0;
	assign dat_o = '0;

endmodule

`default_nettype wire

/* source/wb_ic_master_mux.sv */
//############################################################
// Master response mux
//############################################################
`timescale 1ns/1ps
`default_nettype none

module wb_ic_master_mux (
	input  wire wb_ic_pkg::target_id_t                          tgt_i,
	input  wire wb_ic_pkg::wb_data_t [wb_ic_pkg::N_TARGETS-1:0] t_dat_i,
	input  wire logic [wb_ic_pkg::N_TARGETS-1:0]                t_ack_i,
	input  wire logic [wb_ic_pkg::N_TARGETS-1:0]                t_err_i,
	output wb_ic_pkg::wb_data_t                                 m_dat_o,
	output logic                                                m_ack_o,
	output logic                                                m_err_o
);

	// TGT_NONE matches no slot and leaves the response at zero
	always_comb begin
		m_dat_o = '0;
		m_ack_o = 1'b0;
		m_err_o = 1'b0;
		for (int t = 0; t < wb_ic_pkg::N_TARGETS; t++) begin
			if (tgt_i == wb_ic_pkg::target_id_t'(t)) begin
				m_dat_o = t_dat_i[t];
				m_ack_o = t_ack_i[t];
				m_err_o = t_err_i[t];
			end
		end
	end

	// A target ends an access one way only
	always_comb begin
		a_ack_err_excl : assert final (!(m_ack_o && m_err_o))
			else $error("ACK and ERR together");
	end

endmodule

`default_nettype wire

/* source/wb_ic_target_mux.sv */
//############################################################
// Target request mux
//############################################################
`timescale 1ns/1ps
`default_nettype none

module wb_ic_target_mux (
	input  wire logic                                           gnt_i,
	input  wire wb_ic_pkg::master_id_t                          gnt_id_i,
	input  wire logic [wb_ic_pkg::N_MASTERS-1:0]                m_cyc_i,
	input  wire logic [wb_ic_pkg::N_MASTERS-1:0]                m_stb_i,
	input  wire logic [wb_ic_pkg::N_MASTERS-1:0]                m_we_i,
	input  wire wb_ic_pkg::wb_addr_t [wb_ic_pkg::N_MASTERS-1:0] m_adr_i,
	input  wire wb_ic_pkg::wb_sel_t [wb_ic_pkg::N_MASTERS-1:0]  m_sel_i,
	input  wire wb_ic_pkg::wb_data_t [wb_ic_pkg::N_MASTERS-1:0] m_dat_i,
	output logic                                                t_cyc_o,
	output logic                                                t_stb_o,
	output logic                                                t_we_o,
	output wb_ic_pkg::wb_addr_t                                 t_adr_o,
	output wb_ic_pkg::wb_sel_t                                  t_sel_o,
	output wb_ic_pkg::wb_data_t                                 t_dat_o
);

	// Granted master drives the target, idle bus otherwise
	always_comb begin
		if (gnt_i) begin
			t_cyc_o = m_cyc_i[gnt_id_i];
			t_stb_o = m_stb_i[gnt_id_i];
			t_we_o  = m_we_i[gnt_id_i];
			t_adr_o = m_adr_i[gnt_id_i];
			t_sel_o = m_sel_i[gnt_id_i];
			t_dat_o = m_dat_i[gnt_id_i];
		end else begin
			t_cyc_o = 1'b0;
			t_stb_o = 1'b0;
			t_we_o  = 1'b0;
			t_adr_o = '0;
			t_sel_o = '0;
			t_dat_o = '0;
		end
	end

	// Strobe without a cycle would be a master protocol fault
	always_comb begin
		a_stb_in_cyc : assert final (!t_stb_o || t_cyc_o)
			else $error("target STB without CYC");
	end

endmodule

`default_nettype wire

/* testbench/tb_wb_interconnect.sv */
//############################################################
// Wishbone 2x2 crossbar testbench
//############################################################
`timescale 1ns/1ps
`default_nettype none

module tb_wb_interconnect;

	localparam logic [31:0] SEED = 32'hcb28_41dc;
	localparam int N_TXN          = 200;
	localparam int TIMEOUT_CYCLES = N_TXN * 20 + 100;
	// Longest wait for one response before fairness is called broken
	localparam int MAX_WAIT       = 40;
	localparam int T_RESET  = 0;
	localparam int T_WRRD   = 1;
	localparam int T_DECERR = 2;
	localparam int T_ROUTE  = 3;
	localparam int T_FAIR   = 4;

	logic                clk;
	logic                rstn;
	// Master side, index is the master number
	logic                m_cyc [2];
	logic                m_stb [2];
	logic                m_we [2];
	wb_ic_pkg::wb_addr_t m_adr [2];
	wb_ic_pkg::wb_sel_t  m_sel [2];
	wb_ic_pkg::wb_data_t m_wdat [2];
	wb_ic_pkg::wb_data_t m_rdat [2];
	logic                m_ack [2];
	logic                m_err [2];
	// Slave side
	logic                s_cyc [2];
	logic                s_stb [2];
	logic                s_we [2];
	wb_ic_pkg::wb_addr_t s_adr [2];
	wb_ic_pkg::wb_sel_t  s_sel [2];
	wb_ic_pkg::wb_data_t s_wdat [2];
	wb_ic_pkg::wb_data_t s_rdat [2];
	logic                s_ack [2];
	logic                s_err [2];
	// Master served by each slave, from the word half in the address
	logic                s_owner [2];

	logic [31:0] slave_mem [2][1024];
	logic [31:0] model_mem [2][1024];
	logic        pend [2];
	int          pend_tgt [2];
	int          done_cnt [2];
	int          checks [5];
	int          fails [5];
	int          cycles;
	int          total_fails;
	logic        timed_out;

	wb_interconnect_2x2 i_dut (
		.clk      (clk),
		.rstn     (rstn),
		.m0_cyc_i (m_cyc[0]),
		.m0_stb_i (m_stb[0]),
		.m0_we_i  (m_we[0]),
		.m0_adr_i (m_adr[0]),
		.m0_sel_i (m_sel[0]),
		.m0_dat_i (m_wdat[0]),
		.m0_dat_o (m_rdat[0]),
		.m0_ack_o (m_ack[0]),
		.m0_err_o (m_err[0]),
		.m1_cyc_i (m_cyc[1]),
		.m1_stb_i (m_stb[1]),
		.m1_we_i  (m_we[1]),
		.m1_adr_i (m_adr[1]),
		.m1_sel_i (m_sel[1]),
		.m1_dat_i (m_wdat[1]),
		.m1_dat_o (m_rdat[1]),
		.m1_ack_o (m_ack[1]),
		.m1_err_o (m_err[1]),
		.s0_cyc_o (s_cyc[0]),
		.s0_stb_o (s_stb[0]),
		.s0_we_o  (s_we[0]),
		.s0_adr_o (s_adr[0]),
		.s0_sel_o (s_sel[0]),
		.s0_dat_o (s_wdat[0]),
		.s0_dat_i (s_rdat[0]),
		.s0_ack_i (s_ack[0]),
		.s0_err_i (s_err[0]),
		.s1_cyc_o (s_cyc[1]),
		.s1_stb_o (s_stb[1]),
		.s1_we_o  (s_we[1]),
		.s1_adr_o (s_adr[1]),
		.s1_sel_o (s_sel[1]),
		.s1_dat_o (s_wdat[1]),
		.s1_dat_i (s_rdat[1]),
		.s1_ack_i (s_ack[1]),
		.s1_err_i (s_err[1])
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic string test_name(input int t);
		case (t)
			T_RESET:  return "reset";
			T_WRRD:   return "write_read";
			T_DECERR: return "decode_error";
			T_ROUTE:  return "routing";
			default:  return "fairness";
		endcase
	endfunction

	// Power-up contents, a function of the full byte address
	function automatic logic [31:0] fill_word(input int s, input int idx);
		logic [31:0] a;
		a = ((s == 0) ? wb_ic_pkg::S0_BASE : wb_ic_pkg::S1_BASE) + 32'(idx * 4);
		return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	function automatic logic in_window(input int s, input logic [31:0] adr);
		if (s == 0)
			return adr >= wb_ic_pkg::S0_BASE && adr <= wb_ic_pkg::S0_LIMIT;
		return adr >= wb_ic_pkg::S1_BASE && adr <= wb_ic_pkg::S1_LIMIT;
	endfunction

	task automatic check_value(input int t, input logic [31:0] exp, input logic [31:0] act);
		checks[t]++;
		assert (act === exp) else begin
			$display("CHECK FAILED %s: expected %h, actual %h", test_name(t), exp, act);
			fails[t]++;
		end
	endtask

	task automatic require_true(input int t, input logic cond, input string what);
		checks[t]++;
		assert (cond === 1'b1) else begin
			$display("%s: %s", test_name(t), what);
			fails[t]++;
		end
	endtask

	task automatic report_test(input int t);
		$display("test %s: %s, %0d checks, %0d failures", test_name(t),
			(fails[t] == 0) ? "ok" : "failing", checks[t], fails[t]);
	endtask

	task automatic bus_idle_at_reset();
		check_value(T_RESET, 32'h0, 32'({s_cyc[0], s_stb[0], s_cyc[1], s_stb[1],
			m_ack[0], m_err[0], m_ack[1], m_err[1]}));
	endtask

	// One master, 40/40/20 split over slave 0, slave 1 and unmapped space
	task automatic run_master(input int m);
		logic [31:0] st;
		logic [31:0] adr;
		logic [31:0] wdat;
		logic [31:0] rdat;
		logic [3:0]  sel;
		logic        we;
		logic        got_ack;
		logic        got_err;
		int          n;
		int          kind;
		int          idx;
		int          tgt;
		int          waited;
		int          gap;
		st = SEED + 32'(m * 977);
		for (n = 0; n < N_TXN; n++) begin
			st = lcg_next(st);
			kind = int'((st >> 16) % 10);
			st = lcg_next(st);
			// Each master keeps to its own half of the words
			idx = m * 512 + int'((st >> 16) & 32'h1ff);
			st = lcg_next(st);
			we = st[20];
			sel = st[27:24];
			st = lcg_next(st);
			wdat = st ^ {st[15:0], st[31:16]};
			st = lcg_next(st);
			if (kind < 4) begin
				tgt = 0;
				adr = wb_ic_pkg::S0_BASE + 32'(idx * 4);
			end else if (kind < 8) begin
				tgt = 1;
				adr = wb_ic_pkg::S1_BASE + 32'(idx * 4);
			end else begin
				// Gap between the two windows
				tgt = 2;
				adr = 32'h0000_1000 + ((st >> 8) & 32'h0000_effc);
			end
			@(posedge clk);
			#1;
			m_cyc[m] = 1'b1;
			m_stb[m] = 1'b1;
			m_we[m] = we;
			m_adr[m] = adr;
			m_sel[m] = sel;
			m_wdat[m] = wdat;
			pend_tgt[m] = tgt;
			pend[m] = 1'b1;
			waited = 0;
			got_ack = 1'b0;
			got_err = 1'b0;
			while (!got_ack && !got_err && waited < MAX_WAIT) begin
				@(negedge clk);
				got_ack = m_ack[m];
				got_err = m_err[m];
				rdat = m_rdat[m];
				waited++;
			end
			require_true(T_FAIR, got_ack || got_err,
				$sformatf("master %0d got no response within %0d cycles", m, MAX_WAIT));
			if (tgt == 2) begin
				check_value(T_DECERR, 32'h1, 32'({got_ack, got_err}));
			end else begin
				check_value(T_WRRD, 32'h2, 32'({got_ack, got_err}));
				if (got_ack && we)
					model_mem[tgt][idx] = merge_bytes(model_mem[tgt][idx], wdat, sel);
				else if (got_ack)
					check_value(T_WRRD, model_mem[tgt][idx], rdat);
			end
			// Drop the strobe on the edge after the response
			@(posedge clk);
			#1;
			m_cyc[m] = 1'b0;
			m_stb[m] = 1'b0;
			pend[m] = 1'b0;
			st = lcg_next(st);
			gap = 1 + int'((st >> 16) % 3);
			repeat (gap - 1) @(posedge clk);
			done_cnt[m]++;
		end
	endtask

	// Memory slave, 0 to 3 wait cycles before a one-cycle ACK
	task automatic serve_slave(input int s);
		logic [31:0] st;
		logic [31:0] adr;
		logic        we;
		int          idx;
		int          w;
		st = SEED + 32'((s + 2) * 977);
		forever begin
			@(negedge clk);
			if (s_cyc[s] && s_stb[s]) begin
				adr = s_adr[s];
				we = s_we[s];
				idx = int'(adr[11:2]);
				s_owner[s] = adr[11];
				if (we)
					slave_mem[s][idx] = merge_bytes(slave_mem[s][idx], s_wdat[s], s_sel[s]);
				st = lcg_next(st);
				w = int'((st >> 16) % 4);
				repeat (w) @(negedge clk);
				@(posedge clk);
				#1;
				s_ack[s] = 1'b1;
				s_rdat[s] = we ? 32'h0 : slave_mem[s][idx];
				@(posedge clk);
				#1;
				s_ack[s] = 1'b0;
				s_rdat[s] = 32'h0;
			end
		end
	endtask

	// Address windows at the slaves, response ownership at the masters
	task automatic watch_bus();
		int k;
		forever begin
			@(negedge clk);
			for (int s = 0; s < 2; s++) begin
				if (s_cyc[s])
					require_true(T_ROUTE, in_window(s, s_adr[s]),
						$sformatf("slave %0d saw address %h outside its range", s, s_adr[s]));
			end
			for (int m = 0; m < 2; m++) begin
				k = pend_tgt[m];
				if (m_ack[m])
					require_true(T_ROUTE, pend[m] && k < 2 && s_ack[k] && s_owner[k] == 1'(m),
						$sformatf("master %0d got an ACK from a slave it does not own", m));
				if (m_err[m])
					require_true(T_DECERR, pend[m] && k == 2,
						$sformatf("master %0d got ERR without an unmapped access", m));
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		timed_out = 1'b0;
		total_fails = 0;
		for (int i = 0; i < 2; i++) begin
			m_cyc[i] = 1'b0;
			m_stb[i] = 1'b0;
			m_we[i] = 1'b0;
			m_adr[i] = '0;
			m_sel[i] = '0;
			m_wdat[i] = '0;
			s_rdat[i] = '0;
			s_ack[i] = 1'b0;
			s_err[i] = 1'b0;
			s_owner[i] = 1'b0;
			pend[i] = 1'b0;
			pend_tgt[i] = 3;
			done_cnt[i] = 0;
			for (int j = 0; j < 1024; j++) begin
				slave_mem[i][j] = fill_word(i, j);
				model_mem[i][j] = fill_word(i, j);
			end
		end
		for (int t = 0; t < 5; t++) begin
			checks[t] = 0;
			fails[t] = 0;
		end
		// Reset over four edges, bus checked during and after
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			#1;
			bus_idle_at_reset();
		end
		rstn = 1'b1;
		repeat (2) begin
			@(negedge clk);
			bus_idle_at_reset();
		end
		report_test(T_RESET);
		fork
			run_master(0);
			run_master(1);
			serve_slave(0);
			serve_slave(1);
			watch_bus();
		join_none
		cycles = 0;
		while ((done_cnt[0] < N_TXN || done_cnt[1] < N_TXN) && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (done_cnt[0] < N_TXN || done_cnt[1] < N_TXN) begin
			timed_out = 1'b1;
			$display("timeout: masters did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
		check_value(T_FAIR, 32'(N_TXN), 32'(done_cnt[0]));
		check_value(T_FAIR, 32'(N_TXN), 32'(done_cnt[1]));
		for (int t = 1; t < 5; t++)
			report_test(t);
		for (int t = 0; t < 5; t++)
			total_fails += fails[t];
		$display("total: %0d checks, %0d failures", checks[0] + checks[1] + checks[2] +
			checks[3] + checks[4], total_fails);
		if (total_fails == 0 && !timed_out) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* wb_interconnect/wb_ic_arbiter.sv */
//############################################################
// Round-robin grant-and-hold arbiter
//############################################################
`timescale 1ns/1ps
`default_nettype none

module wb_ic_arbiter #(
	parameter int N_REQ = 2,
	localparam int ID_W = (N_REQ > 1) ? $clog2(N_REQ) : 1
) (
	input  wire logic             clk,
	input  wire logic             rstn,
	input  wire logic [N_REQ-1:0] req_i,
	output logic                  gnt_o,
	output logic [ID_W-1:0]       gnt_id_o
);

	wb_ic_pkg::arb_state_e state;
	logic [N_REQ-1:0]      gnt_oh;
	// One-hot of the most recent grant, used as the rotation point
	logic [N_REQ-1:0]      last_gnt;
	logic [N_REQ-1:0]      above;
	logic [N_REQ-1:0]      cand;
	logic [N_REQ-1:0]      pick_oh;
	logic [ID_W-1:0]       pick_id;
	logic                  seen;

	always_comb begin
		// Positions strictly above the last grant
		seen = 1'b0;
		for (int i = 0; i < N_REQ; i++) begin
			above[i] = seen;
			seen = seen | last_gnt[i];
		end
		// Prefer requesters above the last grant, else wrap to lowest
		cand = ((req_i & above) != '0) ? (req_i & above) : req_i;
		pick_oh = '0;
		pick_id = '0;
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (cand[i]) begin
				pick_oh = '0;
				pick_oh[i] = 1'b1;
				pick_id = ID_W'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state    <= wb_ic_pkg::A_IDLE;
			gnt_oh   <= '0;
			last_gnt <= '0;
			gnt_id_o <= '0;
		end else begin
			case (state)
				wb_ic_pkg::A_IDLE: begin
					if (req_i != '0) begin
						state    <= wb_ic_pkg::A_GRANTED;
						gnt_oh   <= pick_oh;
						last_gnt <= pick_oh;
						gnt_id_o <= pick_id;
					end
				end
				wb_ic_pkg::A_GRANTED: begin
					// Hold until the owner lets go
					if ((gnt_oh & req_i) == '0) begin
						state  <= wb_ic_pkg::A_IDLE;
						gnt_oh <= '0;
					end
				end
				default: state <= wb_ic_pkg::A_IDLE;
			endcase
		end
	end

	assign gnt_o = |gnt_oh;

	a_gnt_onehot : assert property (@(posedge clk) disable iff (!rstn) $onehot0(gnt_oh))
		else $error("more than one grant bit set");

endmodule

`default_nettype wire

/* wb_interconnect/wb_ic_ctrl.sv */
//############################################################
// Crossbar decode and arbitration control
//############################################################
`timescale 1ns/1ps
`default_nettype none

module wb_ic_ctrl (
	input  wire logic                                       clk,
	input  wire logic                                       rstn,
	input  wire logic [wb_ic_pkg::N_MASTERS-1:0]            m_cyc_i,
	input  wire logic [wb_ic_pkg::N_MASTERS-1:0]            m_stb_i,
	input  wire wb_ic_pkg::wb_addr_t [wb_ic_pkg::N_MASTERS-1:0] m_adr_i,
	input  wire logic [wb_ic_pkg::N_MASTERS-1:0]            m_ack_i,
	input  wire logic [wb_ic_pkg::N_MASTERS-1:0]            m_err_i,
	output logic [wb_ic_pkg::N_TARGETS-1:0]                 tgt_gnt_o,
	output wb_ic_pkg::master_id_t [wb_ic_pkg::N_TARGETS-1:0] tgt_gnt_id_o,
	output wb_ic_pkg::target_id_t [wb_ic_pkg::N_MASTERS-1:0] m_tgt_o
);

	// Per-master state and latched target
	wb_ic_pkg::master_state_e        m_state [wb_ic_pkg::N_MASTERS];
	wb_ic_pkg::target_id_t           m_tgt_q [wb_ic_pkg::N_MASTERS];
	// Per-target request vector, one bit per master
	logic [wb_ic_pkg::N_MASTERS-1:0] tgt_req [wb_ic_pkg::N_TARGETS];

	// Address map lookup, anything outside both windows is an error
	function automatic wb_ic_pkg::target_id_t decode(input wb_ic_pkg::wb_addr_t adr);
		if (adr >= wb_ic_pkg::S0_BASE && adr <= wb_ic_pkg::S0_LIMIT)
			return wb_ic_pkg::TGT_S0;
		if (adr >= wb_ic_pkg::S1_BASE && adr <= wb_ic_pkg::S1_LIMIT)
			return wb_ic_pkg::TGT_S1;
		return wb_ic_pkg::TGT_ERR;
	endfunction

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int m = 0; m < wb_ic_pkg::N_MASTERS; m++) begin
				m_state[m] <= wb_ic_pkg::M_IDLE;
				m_tgt_q[m] <= wb_ic_pkg::TGT_NONE;
			end
		end else begin
			for (int m = 0; m < wb_ic_pkg::N_MASTERS; m++) begin
				case (m_state[m])
					wb_ic_pkg::M_IDLE: begin
						// New cycle, latch where it goes
						if (m_cyc_i[m] && m_stb_i[m]) begin
							m_state[m] <= wb_ic_pkg::M_BUSY;
							m_tgt_q[m] <= decode(m_adr_i[m]);
						end
					end
					wb_ic_pkg::M_BUSY: begin
						// Routed ACK or ERR ends the access
						if (m_ack_i[m] || m_err_i[m]) begin
							m_state[m] <= wb_ic_pkg::M_IDLE;
							m_tgt_q[m] <= wb_ic_pkg::TGT_NONE;
						end
					end
					default: m_state[m] <= wb_ic_pkg::M_IDLE;
				endcase
			end
		end
	end

	// A busy master requests the target it latched
	always_comb begin
		for (int t = 0; t < wb_ic_pkg::N_TARGETS; t++) begin
			for (int m = 0; m < wb_ic_pkg::N_MASTERS; m++) begin
				tgt_req[t][m] = (m_state[m] == wb_ic_pkg::M_BUSY) &&
						(m_tgt_q[m] == wb_ic_pkg::target_id_t'(t));
			end
		end
	end

	for (genvar t = 0; t < wb_ic_pkg::N_TARGETS; t++) begin : g_arb
		wb_ic_arbiter #(
			.N_REQ (wb_ic_pkg::N_MASTERS)
		) i_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (tgt_req[t]),
			.gnt_o    (tgt_gnt_o[t]),
			.gnt_id_o (tgt_gnt_id_o[t])
		);
	end

	// Owned target only once that target's arbiter points at this master
	always_comb begin
		for (int m = 0; m < wb_ic_pkg::N_MASTERS; m++) begin
			m_tgt_o[m] = wb_ic_pkg::TGT_NONE;
			for (int t = 0; t < wb_ic_pkg::N_TARGETS; t++) begin
				if (m_state[m] == wb_ic_pkg::M_BUSY &&
						m_tgt_q[m] == wb_ic_pkg::target_id_t'(t) &&
						tgt_gnt_o[t] &&
						tgt_gnt_id_o[t] == wb_ic_pkg::master_id_t'(m))
					m_tgt_o[m] = wb_ic_pkg::target_id_t'(t);
			end
		end
	end

	// A busy master always has a real target latched
	for (genvar m = 0; m < wb_ic_pkg::N_MASTERS; m++) begin : g_chk
		a_busy_has_tgt : assert property (@(posedge clk) disable iff (!rstn)
			(m_state[m] == wb_ic_pkg::M_BUSY) |-> (m_tgt_q[m] != wb_ic_pkg::TGT_NONE))
			else $error("master %0d busy without a target", m);
	end

endmodule

`default_nettype wire

/* wb_interconnect/wb_interconnect_2x2.sv */
//############################################################
// Wishbone 2x2 crossbar top
//############################################################
`timescale 1ns/1ps
`default_nettype none

module wb_interconnect_2x2 (
	input  wire logic                 clk,
	input  wire logic                 rstn,
	// Master 0
	input  wire logic                 m0_cyc_i,
	input  wire logic                 m0_stb_i,
	input  wire logic                 m0_we_i,
	input  wire wb_ic_pkg::wb_addr_t  m0_adr_i,
	input  wire wb_ic_pkg::wb_sel_t   m0_sel_i,
	input  wire wb_ic_pkg::wb_data_t  m0_dat_i,
	output wb_ic_pkg::wb_data_t       m0_dat_o,
	output logic                      m0_ack_o,
	output logic                      m0_err_o,
	// Master 1
	input  wire logic                 m1_cyc_i,
	input  wire logic                 m1_stb_i,
	input  wire logic                 m1_we_i,
	input  wire wb_ic_pkg::wb_addr_t  m1_adr_i,
	input  wire wb_ic_pkg::wb_sel_t   m1_sel_i,
	input  wire wb_ic_pkg::wb_data_t  m1_dat_i,
	output wb_ic_pkg::wb_data_t       m1_dat_o,
	output logic                      m1_ack_o,
	output logic                      m1_err_o,
	// Slave 0
	output logic                      s0_cyc_o,
	output logic                      s0_stb_o,
	output logic                      s0_we_o,
	output wb_ic_pkg::wb_addr_t       s0_adr_o,
	output wb_ic_pkg::wb_sel_t        s0_sel_o,
	output wb_ic_pkg::wb_data_t       s0_dat_o,
	input  wire wb_ic_pkg::wb_data_t  s0_dat_i,
	input  wire logic                 s0_ack_i,
	input  wire logic                 s0_err_i,
	// Slave 1
	output logic                      s1_cyc_o,
	output logic                      s1_stb_o,
	output logic                      s1_we_o,
	output wb_ic_pkg::wb_addr_t       s1_adr_o,
	output wb_ic_pkg::wb_sel_t        s1_sel_o,
	output wb_ic_pkg::wb_data_t       s1_dat_o,
	input  wire wb_ic_pkg::wb_data_t  s1_dat_i,
	input  wire logic                 s1_ack_i,
	input  wire logic                 s1_err_i
);

	// Master request side, index is the master number
	logic [wb_ic_pkg::N_MASTERS-1:0]                     m_cyc;
	logic [wb_ic_pkg::N_MASTERS-1:0]                     m_stb;
	logic [wb_ic_pkg::N_MASTERS-1:0]                     m_we;
	wb_ic_pkg::wb_addr_t [wb_ic_pkg::N_MASTERS-1:0]      m_adr;
	wb_ic_pkg::wb_sel_t [wb_ic_pkg::N_MASTERS-1:0]       m_sel;
	wb_ic_pkg::wb_data_t [wb_ic_pkg::N_MASTERS-1:0]      m_dat_w;
	// Routed responses back to each master
	wb_ic_pkg::wb_data_t [wb_ic_pkg::N_MASTERS-1:0]      m_dat_r;
	logic [wb_ic_pkg::N_MASTERS-1:0]                     m_ack;
	logic [wb_ic_pkg::N_MASTERS-1:0]                     m_err;
	wb_ic_pkg::target_id_t [wb_ic_pkg::N_MASTERS-1:0]    m_tgt;

	// Target side, index 2 is the error target
	logic [wb_ic_pkg::N_TARGETS-1:0]                     t_gnt;
	wb_ic_pkg::master_id_t [wb_ic_pkg::N_TARGETS-1:0]    t_gnt_id;
	logic [wb_ic_pkg::N_TARGETS-1:0]                     t_cyc;
	logic [wb_ic_pkg::N_TARGETS-1:0]                     t_stb;
	logic [wb_ic_pkg::N_TARGETS-1:0]                     t_we;
	wb_ic_pkg::wb_addr_t [wb_ic_pkg::N_TARGETS-1:0]      t_adr;
	wb_ic_pkg::wb_sel_t [wb_ic_pkg::N_TARGETS-1:0]       t_sel;
	wb_ic_pkg::wb_data_t [wb_ic_pkg::N_TARGETS-1:0]      t_dat_w;
	wb_ic_pkg::wb_data_t [wb_ic_pkg::N_TARGETS-1:0]      t_dat_r;
	logic [wb_ic_pkg::N_TARGETS-1:0]                     t_ack;
	logic [wb_ic_pkg::N_TARGETS-1:0]                     t_err;

	assign m_cyc   = {m1_cyc_i, m0_cyc_i};
	assign m_stb   = {m1_stb_i, m0_stb_i};
	assign m_we    = {m1_we_i, m0_we_i};
	assign m_adr   = {m1_adr_i, m0_adr_i};
	assign m_sel   = {m1_sel_i, m0_sel_i};
	assign m_dat_w = {m1_dat_i, m0_dat_i};

	assign m0_dat_o = m_dat_r[0];
	assign m0_ack_o = m_ack[0];
	assign m0_err_o = m_err[0];
	assign m1_dat_o = m_dat_r[1];
	assign m1_ack_o = m_ack[1];
	assign m1_err_o = m_err[1];

	assign {s0_cyc_o, s0_stb_o, s0_we_o} = {t_cyc[0], t_stb[0], t_we[0]};
	assign {s0_adr_o, s0_sel_o, s0_dat_o} = {t_adr[0], t_sel[0], t_dat_w[0]};
	assign {s1_cyc_o, s1_stb_o, s1_we_o} = {t_cyc[1], t_stb[1], t_we[1]};
	assign {s1_adr_o, s1_sel_o, s1_dat_o} = {t_adr[1], t_sel[1], t_dat_w[1]};

	// Slave responses, the error target fills slot 2 below
	assign t_dat_r[1:0] = {s1_dat_i, s0_dat_i};
	assign t_ack[1:0]   = {s1_ack_i, s0_ack_i};
	assign t_err[1:0]   = {s1_err_i, s0_err_i};

	wb_ic_ctrl i_ctrl (
		.clk          (clk),
		.rstn         (rstn),
		.m_cyc_i      (m_cyc),
		.m_stb_i      (m_stb),
		.m_adr_i      (m_adr),
		.m_ack_i      (m_ack),
		.m_err_i      (m_err),
		.tgt_gnt_o    (t_gnt),
		.tgt_gnt_id_o (t_gnt_id),
		.m_tgt_o      (m_tgt)
	);

	// One request mux per target
	for (genvar t = 0; t < wb_ic_pkg::N_TARGETS; t++) begin : g_tmux
		wb_ic_target_mux i_tmux (
			.gnt_i    (t_gnt[t]),
			.gnt_id_i (t_gnt_id[t]),
			.m_cyc_i  (m_cyc),
			.m_stb_i  (m_stb),
			.m_we_i   (m_we),
			.m_adr_i  (m_adr),
			.m_sel_i  (m_sel),
			.m_dat_i  (m_dat_w),
			.t_cyc_o  (t_cyc[t]),
			.t_stb_o  (t_stb[t]),
			.t_we_o   (t_we[t]),
			.t_adr_o  (t_adr[t]),
			.t_sel_o  (t_sel[t]),
			.t_dat_o  (t_dat_w[t])
		);
	end

	// One response mux per master
	for (genvar m = 0; m < wb_ic_pkg::N_MASTERS; m++) begin : g_mmux
		wb_ic_master_mux i_mmux (
			.tgt_i   (m_tgt[m]),
			.t_dat_i (t_dat_r),
			.t_ack_i (t_ack),
			.t_err_i (t_err),
			.m_dat_o (m_dat_r[m]),
			.m_ack_o (m_ack[m]),
			.m_err_o (m_err[m])
		);
	end

	// Unmapped addresses end up here
	wb_ic_err_target i_err_tgt (
		.clk   (clk),
		.rstn  (rstn),
		.cyc_i (t_cyc[wb_ic_pkg::TGT_ERR]),
		.stb_i (t_stb[wb_ic_pkg::TGT_ERR]),
		.dat_o (t_dat_r[wb_ic_pkg::TGT_ERR]),
		.ack_o (t_ack[wb_ic_pkg::TGT_ERR]),
		.err_o (t_err[wb_ic_pkg::TGT_ERR])
	);

endmodule

`default_nettype wire
